//--- bsr_pkg.sv
package bsr_pkg;

    // ====================
    // Data and block geometry
    // ====================
    localparam int DATA_W      = 8;                       // One INT8 weight
    localparam int BLOCK_DIM   = 8;                       // Block is BLOCK_DIM x BLOCK_DIM
    localparam int BLOCK_BYTES = BLOCK_DIM * BLOCK_DIM;   // 64 weights per block
    localparam int BYTE_CNT_W  = $clog2(BLOCK_BYTES);     // Byte counter, 6 bits
    localparam int BLOCK_W     = BLOCK_BYTES * DATA_W;    // Packed block, byte k at [8k+7:8k]

    // Index widths
    localparam int ROW_W = 16;  // Block row numbers, row pointer addresses
    localparam int COL_W = 16;  // Column indices
    localparam int IDX_W = 32;  // Block indices, pointer data, byte addresses

    // ====================
    // State encodings
    // ====================
    typedef enum logic [3:0] {
        S_IDLE,       // Wait for start
        S_ROW_FETCH,  // Request first row
        S_ROW_WAIT,   // Wait for row pointer pair
        S_BLK_LOAD,   // Kick the loader
        S_LOAD_WAIT,  // Block in buffer and array free
        S_ISSUE,      // Hand block to issue stage
        S_NEXT_BLK,   // Wait for handshake, step index
        S_NEXT_ROW,   // Request next row
        S_DRAIN,      // Last computation still running
        S_FINISH      // Raise done
    } sched_state_t;

    typedef enum logic [2:0] {
        LD_IDLE,
        LD_COL_RD,    // Column index read
        LD_COL_CAP,   // Column index capture
        LD_BYTES,     // 64 byte reads
        LD_DONE       // Last byte lands
    } load_state_t;

endpackage

//--- bsr_row_fetch.sv
`timescale 1ns/1ns

module bsr_row_fetch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      row_first,
    input  logic                      row_next,
    input  logic [bsr_pkg::ROW_W-1:0] cfg_num_block_rows,
    output logic                      row_ptr_rd_en,
    output logic [bsr_pkg::ROW_W-1:0] row_ptr_rd_addr,
    input  logic [bsr_pkg::IDX_W-1:0] row_ptr_rd_data,
    output logic                      row_valid,
    output logic                      row_empty,
    output logic                      row_last,
    output logic [bsr_pkg::ROW_W-1:0] block_row,
    output logic [bsr_pkg::IDX_W-1:0] block_start,
    output logic [bsr_pkg::IDX_W-1:0] block_end
);
    import bsr_pkg::*;

    logic ph1;  // Start pointer on read port, end pointer being read
    logic ph2;  // End pointer on read port

    // ====================
    // Pointer reads
    // ====================
    // Cycle 0 reads row_ptr[row], cycle 1 reads row_ptr[row+1]
    assign row_ptr_rd_en   = row_first || row_next || ph1;
    assign row_ptr_rd_addr = row_first ? '0 : block_row + ROW_W'(1);  // Counter not yet stepped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block_row <= '0;
            ph1       <= 1'b0;
            ph2       <= 1'b0;
            row_valid <= 1'b0;
        end else begin
            if (row_first)
                block_row <= '0;
            else if (row_next)
                block_row <= block_row + ROW_W'(1);
            ph1       <= row_first || row_next;
            ph2       <= ph1;
            row_valid <= ph2;  // Three cycles after the request
        end
    end

    // ====================
    // Range capture
    // ====================
    always_ff @(posedge clk) begin
        if (ph1)
            block_start <= row_ptr_rd_data;
        if (ph2) begin
            block_end <= row_ptr_rd_data;
            row_empty <= (row_ptr_rd_data == block_start);                 // No blocks in row
            row_last  <= (block_row == cfg_num_block_rows - ROW_W'(1));
        end
    end

    // Row pointers must be non-decreasing in memory
    a_range_order: assert property (@(posedge clk) disable iff (!rst_n)
        row_valid |-> (block_end >= block_start));

endmodule

//--- bsr_block_loader.sv
`timescale 1ns/1ns

module bsr_block_loader (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_start,
    input  logic [bsr_pkg::IDX_W-1:0]   block_idx,
    output logic                        col_idx_rd_en,
    output logic [bsr_pkg::IDX_W-1:0]   col_idx_rd_addr,
    input  logic [bsr_pkg::COL_W-1:0]   col_idx_rd_data,
    output logic                        block_rd_en,
    output logic [bsr_pkg::IDX_W-1:0]   block_rd_addr,
    input  logic [bsr_pkg::DATA_W-1:0]  block_rd_data,
    output logic                        load_done,
    output logic [bsr_pkg::COL_W-1:0]   block_col,
    output logic [bsr_pkg::BLOCK_W-1:0] block_data
);
    import bsr_pkg::*;

    load_state_t            ld_state;
    logic [IDX_W-1:0]       blk_idx;   // Block being loaded
    logic [BYTE_CNT_W-1:0]  byte_cnt;  // Byte address within block
    logic                   cap_en;    // Byte on read port this cycle
    logic [BYTE_CNT_W-1:0]  cap_idx;   // Which byte it is

    // ====================
    // Memory ports
    // ====================
    assign col_idx_rd_en   = (ld_state == LD_COL_RD);
    assign col_idx_rd_addr = blk_idx;
    assign block_rd_en     = (ld_state == LD_BYTES);
    assign block_rd_addr   = {blk_idx[IDX_W-BYTE_CNT_W-1:0], byte_cnt};  // idx*64 + byte
    assign load_done       = (ld_state == LD_DONE);  // Last byte written on this edge

    // ====================
    // Load sequence
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_state <= LD_IDLE;
            byte_cnt <= '0;
            cap_en   <= 1'b0;
        end else begin
            cap_en <= block_rd_en;  // Read data follows address by one cycle
            case (ld_state)
                LD_IDLE: begin
                    if (load_start)
                        ld_state <= LD_COL_RD;
                end
                LD_COL_RD:  ld_state <= LD_COL_CAP;
                LD_COL_CAP: begin
                    byte_cnt <= '0;
                    ld_state <= LD_BYTES;
                end
                LD_BYTES: begin
                    byte_cnt <= byte_cnt + BYTE_CNT_W'(1);
                    if (byte_cnt == BYTE_CNT_W'(BLOCK_BYTES - 1))
                        ld_state <= LD_DONE;
                end
                LD_DONE:    ld_state <= LD_IDLE;
                default:    ld_state <= LD_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (load_start)
            blk_idx <= block_idx;
        if (ld_state == LD_COL_CAP)
            block_col <= col_idx_rd_data;
        cap_idx <= byte_cnt;
        if (cap_en)
            block_data[cap_idx*DATA_W +: DATA_W] <= block_rd_data;  // Byte k at [8k+7:8k]
    end

    // Sequencer must wait for load_done before the next request
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        load_start |-> (ld_state == LD_IDLE));

endmodule

//--- bsr_block_issue.sv
`timescale 1ns/1ns

module bsr_block_issue (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        issue_start,
    input  logic [bsr_pkg::BLOCK_W-1:0] block_data,
    input  logic [bsr_pkg::ROW_W-1:0]   block_row,
    input  logic [bsr_pkg::COL_W-1:0]   block_col,
    input  logic                        systolic_ready,
    input  logic                        systolic_done,
    input  logic                        count_clear,
    output logic                        issue_idle,
    output logic                        issue_accepted,
    output logic                        systolic_valid,
    output logic [bsr_pkg::BLOCK_W-1:0] systolic_block,
    output logic [bsr_pkg::ROW_W-1:0]   systolic_block_row,
    output logic [bsr_pkg::COL_W-1:0]   systolic_block_col,
    output logic [bsr_pkg::IDX_W-1:0]   blocks_processed
);
    import bsr_pkg::*;

    logic pending;   // Block latched, computation not finished
    logic finish;    // Done seen after the handshake

    assign issue_idle     = !pending;
    assign issue_accepted = systolic_valid && systolic_ready;    // Handshake cycle
    assign finish         = pending && !systolic_valid && systolic_done;  // Stray done dropped

    // ====================
    // Handshake and completion
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending          <= 1'b0;
            systolic_valid   <= 1'b0;
            blocks_processed <= '0;
        end else begin
            if (issue_start) begin
                pending        <= 1'b1;
                systolic_valid <= 1'b1;
            end else if (issue_accepted) begin
                systolic_valid <= 1'b0;  // Array owns the block now
            end else if (finish) begin
                pending <= 1'b0;
            end
            if (count_clear)
                blocks_processed <= '0;
            else if (finish)
                blocks_processed <= blocks_processed + IDX_W'(1);
        end
    end

    // Private copy so the loader can refill after the handshake
    always_ff @(posedge clk) begin
        if (issue_start) begin
            systolic_block     <= block_data;
            systolic_block_row <= block_row;
            systolic_block_col <= block_col;
        end
    end

    a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (systolic_valid && !systolic_ready) |=> (systolic_valid && $stable(systolic_block)
            && $stable(systolic_block_row) && $stable(systolic_block_col)));

endmodule

//--- bsr_sched_fsm.sv
`timescale 1ns/1ns

module bsr_sched_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    // Row fetch side
    output logic                      row_first,
    output logic                      row_next,
    input  logic                      row_valid,
    input  logic                      row_empty,
    input  logic                      row_last,
    input  logic [bsr_pkg::IDX_W-1:0] block_start,
    input  logic [bsr_pkg::IDX_W-1:0] block_end,
    // Loader side
    output logic                      load_start,
    output logic [bsr_pkg::IDX_W-1:0] block_idx,
    input  logic                      load_done,
    // Issue side
    output logic                      issue_start,
    input  logic                      issue_idle,
    input  logic                      issue_accepted,
    output logic                      count_clear,
    // Status
    output logic                      busy,
    output logic                      done
);
    import bsr_pkg::*;

    sched_state_t state;
    logic         loaded;  // Buffer holds a block not yet issued

    // ====================
    // Request pulses
    // ====================
    // Each request state lasts one cycle
    assign row_first   = (state == S_ROW_FETCH);
    assign row_next    = (state == S_NEXT_ROW);
    assign load_start  = (state == S_BLK_LOAD);
    assign issue_start = (state == S_ISSUE);      // Only reached with issue_idle high
    assign count_clear = (state == S_IDLE) && start;

    // ====================
    // Sequencer
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            block_idx <= '0;
            loaded    <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (load_done)
                loaded <= 1'b1;
            else if (issue_start)
                loaded <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (start) begin
                        busy  <= 1'b1;
                        done  <= 1'b0;  // Held from previous walk until now
                        state <= S_ROW_FETCH;
                    end
                end
                S_ROW_FETCH: state <= S_ROW_WAIT;
                S_ROW_WAIT: begin
                    if (row_valid) begin
                        if (!row_empty) begin
                            block_idx <= block_start;  // First block of the row
                            state     <= S_BLK_LOAD;
                        end else if (row_last) begin
                            state <= S_DRAIN;
                        end else begin
                            state <= S_NEXT_ROW;  // Skip empty row
                        end
                    end
                end
                S_BLK_LOAD: state <= S_LOAD_WAIT;
                S_LOAD_WAIT: begin
                    // Previous block may still be computing
                    if ((loaded || load_done) && issue_idle)
                        state <= S_ISSUE;
                end
                S_ISSUE: state <= S_NEXT_BLK;
                S_NEXT_BLK: begin
                    if (issue_accepted) begin
                        block_idx <= block_idx + IDX_W'(1);
                        if (block_idx + IDX_W'(1) != block_end)
                            state <= S_BLK_LOAD;  // Overlaps with compute
                        else if (row_last)
                            state <= S_DRAIN;
                        else
                            state <= S_NEXT_ROW;
                    end
                end
                S_NEXT_ROW: state <= S_ROW_WAIT;
                S_DRAIN: begin
                    if (issue_idle)
                        state <= S_FINISH;
                end
                S_FINISH: begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // A start during a walk never relaunches the row fetch
    a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (start && busy) |=> (state != S_ROW_FETCH));

endmodule

//--- bsr_scheduler.sv
`timescale 1ns/1ns

module bsr_scheduler (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [bsr_pkg::ROW_W-1:0]   cfg_num_block_rows,
    // Row pointer memory
    output logic                        row_ptr_rd_en,
    output logic [bsr_pkg::ROW_W-1:0]   row_ptr_rd_addr,
    input  logic [bsr_pkg::IDX_W-1:0]   row_ptr_rd_data,
    // Column index memory
    output logic                        col_idx_rd_en,
    output logic [bsr_pkg::IDX_W-1:0]   col_idx_rd_addr,
    input  logic [bsr_pkg::COL_W-1:0]   col_idx_rd_data,
    // Block weight memory
    output logic                        block_rd_en,
    output logic [bsr_pkg::IDX_W-1:0]   block_rd_addr,
    input  logic [bsr_pkg::DATA_W-1:0]  block_rd_data,
    // Systolic array
    output logic                        systolic_valid,
    output logic [bsr_pkg::BLOCK_W-1:0] systolic_block,
    output logic [bsr_pkg::ROW_W-1:0]   systolic_block_row,
    output logic [bsr_pkg::COL_W-1:0]   systolic_block_col,
    input  logic                        systolic_ready,
    input  logic                        systolic_done,
    // Status
    output logic                        done,
    output logic                        busy,
    output logic [bsr_pkg::IDX_W-1:0]   blocks_processed
);
    import bsr_pkg::*;

    // ====================
    // Internal nets
    // ====================
    logic               row_first, row_next, row_valid, row_empty, row_last;
    logic [ROW_W-1:0]   block_row;
    logic [IDX_W-1:0]   block_start, block_end, block_idx;
    logic               load_start, load_done;
    logic [COL_W-1:0]   block_col;
    logic [BLOCK_W-1:0] block_data;
    logic               issue_start, issue_idle, issue_accepted, count_clear;

    bsr_sched_fsm u_fsm (
        .clk, .rst_n, .start,
        .row_first, .row_next, .row_valid, .row_empty, .row_last,
        .block_start, .block_end,
        .load_start, .block_idx, .load_done,
        .issue_start, .issue_idle, .issue_accepted, .count_clear,
        .busy, .done
    );

    bsr_row_fetch u_row_fetch (
        .clk, .rst_n, .row_first, .row_next, .cfg_num_block_rows,
        .row_ptr_rd_en, .row_ptr_rd_addr, .row_ptr_rd_data,
        .row_valid, .row_empty, .row_last,
        .block_row, .block_start, .block_end
    );

    bsr_block_loader u_loader (
        .clk, .rst_n, .load_start, .block_idx,
        .col_idx_rd_en, .col_idx_rd_addr, .col_idx_rd_data,
        .block_rd_en, .block_rd_addr, .block_rd_data,
        .load_done, .block_col, .block_data
    );

    bsr_block_issue u_issue (
        .clk, .rst_n, .issue_start,
        .block_data, .block_row, .block_col,
        .systolic_ready, .systolic_done, .count_clear,
        .issue_idle, .issue_accepted,
        .systolic_valid, .systolic_block, .systolic_block_row, .systolic_block_col,
        .blocks_processed
    );

endmodule

//--- tb_bsr_models.sv
`timescale 1ns/1ns

module tb_bsr_models (
    input  logic                       clk,
    // Memory read ports, data one cycle after the address
    input  logic                       row_ptr_rd_en,
    input  logic [bsr_pkg::ROW_W-1:0]  row_ptr_rd_addr,
    output logic [bsr_pkg::IDX_W-1:0]  row_ptr_rd_data,
    input  logic                       col_idx_rd_en,
    input  logic [bsr_pkg::IDX_W-1:0]  col_idx_rd_addr,
    output logic [bsr_pkg::COL_W-1:0]  col_idx_rd_data,
    input  logic                       block_rd_en,
    input  logic [bsr_pkg::IDX_W-1:0]  block_rd_addr,
    output logic [bsr_pkg::DATA_W-1:0] block_rd_data,
    // Systolic array side
    input  logic                       systolic_valid,
    output logic                       systolic_ready,
    output logic                       systolic_done,
    input  logic [2:0]                 ready_dly,  // Cycles of valid before ready
    input  logic [2:0]                 done_dly    // Extra compute cycles after accept
);
    import bsr_pkg::*;

    logic [IDX_W-1:0] row_ptr_mem [0:7];  // Loaded hierarchically between walks
    enum logic [1:0] {SA_WAIT, SA_ACCEPT, SA_COMPUTE, SA_DONE} phase;
    logic [2:0]       cnt;

    initial begin
        row_ptr_rd_data = '0;
        col_idx_rd_data = '0;
        block_rd_data   = '0;
        systolic_ready  = 1'b0;
        systolic_done   = 1'b0;
        phase           = SA_WAIT;
        cnt             = '0;
    end

    // ====================
    // Memories
    // ====================
    always @(posedge clk) begin
        if (row_ptr_rd_en)
            row_ptr_rd_data <= row_ptr_mem[row_ptr_rd_addr[2:0]];
        if (col_idx_rd_en)
            col_idx_rd_data <= COL_W'(col_idx_rd_addr * 3 + 1);  // Column of block j is 3j+1
        if (block_rd_en)  // Byte k of block j is j*13+k
            block_rd_data <= DATA_W'((block_rd_addr >> BYTE_CNT_W) * 13 + (block_rd_addr & 63));
    end

    // ====================
    // Systolic array
    // ====================
    always @(negedge clk) begin
        case (phase)
            SA_WAIT: begin
                if (systolic_valid) begin
                    if (cnt >= ready_dly) begin
                        systolic_ready <= 1'b1;  // Handshake on the next rising edge
                        phase          <= SA_ACCEPT;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
            end
            SA_ACCEPT: begin
                systolic_ready <= 1'b0;
                cnt            <= '0;
                phase          <= SA_COMPUTE;
            end
            SA_COMPUTE: begin
                if (cnt >= done_dly) begin
                    systolic_done <= 1'b1;  // One-cycle pulse
                    phase         <= SA_DONE;
                end else begin
                    cnt <= cnt + 3'd1;
                end
            end
            default: begin
                systolic_done <= 1'b0;
                cnt           <= '0;
                phase         <= SA_WAIT;
            end
        endcase
    end

endmodule

//--- tb_bsr_scheduler.sv
`timescale 1ns/1ns

module tb_bsr_scheduler;
    import bsr_pkg::*;

    localparam int NUM_CASES = 7;
    localparam int TIMEOUT   = 4000;  // Cycles allowed per wait

    // ====================
    // Case table
    // ====================
    // Block rows, row pointers, random array delays
    int case_rows [NUM_CASES]    = '{4, 4, 3, 2, 4, 1, 4};
    int case_ptr  [NUM_CASES][5] = '{
        '{0, 2, 3, 3, 5},   // Empty row in the middle
        '{0, 0, 2, 4, 4},   // First and last rows empty
        '{0, 3, 3, 6, 0},
        '{0, 0, 0, 0, 0},   // No blocks at all
        '{0, 1, 4, 5, 7},
        '{0, 4, 0, 0, 0},   // Single row
        '{0, 2, 3, 3, 5}    // First case again, random delays
    };
    bit case_rnd [NUM_CASES] = '{0, 0, 1, 0, 1, 1, 1};

    logic                clk = 1'b0;
    logic                rst_n;
    logic                start;
    logic [ROW_W-1:0]    cfg_num_block_rows;
    logic                row_ptr_rd_en;
    logic [ROW_W-1:0]    row_ptr_rd_addr;
    logic [IDX_W-1:0]    row_ptr_rd_data;
    logic                col_idx_rd_en;
    logic [IDX_W-1:0]    col_idx_rd_addr;
    logic [COL_W-1:0]    col_idx_rd_data;
    logic                block_rd_en;
    logic [IDX_W-1:0]    block_rd_addr;
    logic [DATA_W-1:0]   block_rd_data;
    logic                systolic_valid;
    logic [BLOCK_W-1:0]  systolic_block;
    logic [ROW_W-1:0]    systolic_block_row;
    logic [COL_W-1:0]    systolic_block_col;
    logic                systolic_ready;
    logic                systolic_done;
    logic                done;
    logic                busy;
    logic [IDX_W-1:0]    blocks_processed;
    logic [2:0]          ready_dly = 3'd0;
    logic [2:0]          done_dly = 3'd0;
    bit                  rand_mode;
    bit                  timed_out;
    int                  seed = 44;
    int                  errors = 0;
    int                  timeouts = 0;
    int                  exp_blk_q [$];  // Expected block indices, oldest first
    logic [ROW_W-1:0]    exp_row_q [$];
    logic                prev_stall = 1'b0;  // Valid without ready on the last edge
    logic [ROW_W+COL_W+BLOCK_W-1:0] prev_payload;
    int                  row_rd_cnt = 0;   // Running totals of memory read cycles
    int                  col_rd_cnt = 0;
    int                  byte_rd_cnt = 0;

    always #20 clk = ~clk;

    bsr_scheduler uut (.*);
    tb_bsr_models u_models (.*);

    // Fixed delays, or fresh random ones every cycle
    always @(posedge clk) begin
        ready_dly <= rand_mode ? 3'($random(seed)) : 3'd0;
        done_dly  <= rand_mode ? 3'($random(seed)) : 3'd3;
    end

    function automatic logic [DATA_W-1:0] weight_byte(int blk, int k);
        return DATA_W'(blk * 13 + k);
    endfunction

    function automatic logic [COL_W-1:0] col_index(int blk);
        return COL_W'(blk * 3 + 1);
    endfunction

    task automatic log_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
        errors++;
    endtask

    // Walk the pointer list in block order
    function automatic void build_expected(int c);
        exp_blk_q.delete();
        exp_row_q.delete();
        for (int r = 0; r < case_rows[c]; r++) begin
            for (int j = case_ptr[c][r]; j < case_ptr[c][r + 1]; j++) begin
                exp_blk_q.push_back(j);
                exp_row_q.push_back(ROW_W'(r));
            end
        end
    endfunction

    task automatic check_block();
        int               blk;
        logic [ROW_W-1:0] row;
        assert (exp_blk_q.size() > 0) else begin
            $display("Handshake for row %0d with no block left to expect", systolic_block_row);
            errors++;
        end
        if (exp_blk_q.size() > 0) begin
            blk = exp_blk_q.pop_front();
            row = exp_row_q.pop_front();
            assert (systolic_block_row == row)
                else log_mismatch("systolic_block_row", 64'(systolic_block_row), 64'(row));
            assert (systolic_block_col == col_index(blk))
                else log_mismatch("systolic_block_col", 64'(systolic_block_col),
                                  64'(col_index(blk)));
            for (int k = 0; k < BLOCK_BYTES; k++) begin
                assert (systolic_block[k*DATA_W +: DATA_W] == weight_byte(blk, k))
                    else log_mismatch($sformatf("systolic_block byte %0d", k),
                                      64'(systolic_block[k*DATA_W +: DATA_W]),
                                      64'(weight_byte(blk, k)));
            end
        end
    endtask

    // ====================
    // Array-side monitor
    // ====================
    always @(posedge clk) begin
        if (rst_n) begin
            if (row_ptr_rd_en)  // Read strobes seen by the memories
                row_rd_cnt++;
            if (col_idx_rd_en)
                col_rd_cnt++;
            if (block_rd_en)
                byte_rd_cnt++;
            if (prev_stall) begin  // Stalled offer must hold
                assert (systolic_valid) else begin
                    $display("systolic_valid dropped at %0t before ready", $time);
                    errors++;
                end
                assert ({systolic_block_row, systolic_block_col, systolic_block} == prev_payload)
                    else begin
                    $display("MISMATCH systolic_block held: got 0x%h, expected 0x%h",
                             {systolic_block_row, systolic_block_col, systolic_block},
                             prev_payload);
                    errors++;
                end
            end
            if (systolic_valid && systolic_ready)
                check_block();
        end
        prev_stall   <= systolic_valid && !systolic_ready;
        prev_payload <= {systolic_block_row, systolic_block_col, systolic_block};
    end

    task automatic run_walk(int c);
        int cycles;
        int exp_count;
        int exp_blocks;
        int row_base;
        int col_base;
        int byte_base;
        @(negedge clk);
        for (int i = 0; i < 5; i++)
            u_models.row_ptr_mem[i] = IDX_W'(case_ptr[c][i]);
        cfg_num_block_rows = ROW_W'(case_rows[c]);
        rand_mode          = case_rnd[c];
        exp_count          = case_ptr[c][case_rows[c]];
        build_expected(c);
        exp_blocks = exp_blk_q.size();
        row_base   = row_rd_cnt;
        col_base   = col_rd_cnt;
        byte_base  = byte_rd_cnt;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        assert (!done) else log_mismatch("done", 64'(done), 64'(0));
        assert (blocks_processed == '0)
            else log_mismatch("blocks_processed", 64'(blocks_processed), 64'(0));
        cycles = 0;
        while (!done && cycles < TIMEOUT) begin
            assert (busy) else log_mismatch("busy", 64'(busy), 64'(1));
            @(negedge clk);
            cycles++;
        end
        assert (done) else begin
            $display("Case %0d: walk did not finish within %0d cycles", c, TIMEOUT);
            timeouts++;
            timed_out = 1'b1;
        end
        if (done) begin
            assert (exp_blk_q.size() == 0) else begin
                $display("Case %0d: %0d blocks never reached the array", c, exp_blk_q.size());
                errors++;
            end
            assert (blocks_processed == IDX_W'(exp_count))
                else log_mismatch("blocks_processed", 64'(blocks_processed), 64'(exp_count));
            assert (!busy) else log_mismatch("busy", 64'(busy), 64'(0));
            // Two pointer reads per row, one column read and 64 byte reads per block
            assert (row_rd_cnt - row_base == 2 * case_rows[c])
                else log_mismatch("row_ptr_rd_en cycles", 64'(row_rd_cnt - row_base),
                                  64'(2 * case_rows[c]));
            assert (col_rd_cnt - col_base == exp_blocks)
                else log_mismatch("col_idx_rd_en cycles", 64'(col_rd_cnt - col_base),
                                  64'(exp_blocks));
            assert (byte_rd_cnt - byte_base == BLOCK_BYTES * exp_blocks)
                else log_mismatch("block_rd_en cycles", 64'(byte_rd_cnt - byte_base),
                                  64'(BLOCK_BYTES * exp_blocks));
            repeat (2) @(negedge clk);
            assert (done) else log_mismatch("done", 64'(done), 64'(1));  // Held until start
        end
    endtask

    initial begin
        rst_n              = 1'b0;
        start              = 1'b0;
        cfg_num_block_rows = '0;
        rand_mode          = 1'b0;
        timed_out          = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        for (int c = 0; c < NUM_CASES; c++) begin
            if (!timed_out)
                run_walk(c);
        end
        $display("Errors: %0d failed checks, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- project.f
bsr_pkg.sv
bsr_row_fetch.sv
bsr_block_loader.sv
bsr_block_issue.sv
bsr_sched_fsm.sv
bsr_scheduler.sv
tb_bsr_models.sv
tb_bsr_scheduler.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the BSR scheduler testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
    --top-module tb_bsr_scheduler -o sim_bsr
./obj_dir/sim_bsr | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation passed"
